// File: Bender.yml
package:
  name: fp32_mul

sources:
  # Package first, then the stages, then the top level
  - src/fp32_pkg.sv
  - src/fp_decode_stage.sv
  - src/fp_mul_stage.sv
  - src/fp_normalizer.sv
  - src/fp_round_stage.sv
  - src/fp32_mul.sv

  - target: simulation
    files:
      - verif/fp32_mul_chk.sv
      - verif/fp32_mul_tb.sv

// File: fp32_mul.f
src/fp32_pkg.sv
src/fp_decode_stage.sv
src/fp_mul_stage.sv
src/fp_normalizer.sv
src/fp_round_stage.sv
src/fp32_mul.sv
verif/fp32_mul_chk.sv
verif/fp32_mul_tb.sv

// File: src/fp32_mul.sv
module fp32_mul
    import fp32_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  fp_word_t a,
    input  fp_word_t b,
    input  logic     in_valid,
    output logic     out_valid,
    output fp_word_t result
);

    logic      s1_valid;                            // Decode done
    dec_pair_t s1_dec;
    logic      s2_valid;                            // Product ready
    mul_res_t  s2_res;

    // Three stages, one cycle each
    fp_decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .valid    (s1_valid),
        .dec      (s1_dec)
    );

    fp_mul_stage u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (s1_valid),
        .dec      (s1_dec),
        .valid    (s2_valid),
        .res      (s2_res)
    );

    fp_round_stage u_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (s2_valid),
        .res       (s2_res),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

// File: src/fp32_pkg.sv
package fp32_pkg;

    localparam int EXP_BITS = 8;                    // Biased exponent field
    localparam int MAN_BITS = 23;                   // Stored fraction field
    localparam int FP_BIAS  = 127;
    localparam int EXP_MAX  = 255;                  // All-ones exponent, Inf or NaN

    // Bit positions inside one FP32 word
    localparam int SGN_BIT  = EXP_BITS + MAN_BITS;

    typedef logic [SGN_BIT:0]          fp_word_t;   // One FP32 value
    typedef logic [EXP_BITS-1:0]       exp_t;       // Biased exponent
    typedef logic [MAN_BITS:0]         sig_t;       // Significand with hidden bit
    typedef logic [MAN_BITS-1:0]       frac_t;      // Fraction only
    typedef logic signed [EXP_BITS+1:0] wide_exp_t; // Keeps overflow and underflow visible
    typedef logic [2*MAN_BITS+1:0]     prod_t;      // Full 24 x 24 product

    localparam fp_word_t QNAN_WORD = 32'h7FC0_0000; // Canonical quiet NaN

    typedef enum logic [2:0] {
        FP_ZERO,
        FP_SUB,
        FP_NORM,
        FP_INF,
        FP_NAN
    } fp_class_e;

    // One decoded operand, 36 bits
    typedef struct packed {
        logic      sign;
        fp_class_e cls;
        exp_t      exp;                             // Effective exponent, 1 for subnormals
        sig_t      sig;
    } dec_operand_t;

    typedef struct packed {
        dec_operand_t a;
        dec_operand_t b;
    } dec_pair_t;

    // Stage 2 to stage 3 payload
    typedef struct packed {
        logic      sign;
        wide_exp_t exp;                             // Provisional, before normalization
        prod_t     prod;
        logic      is_special;                      // Result already decided
        fp_word_t  special;
    } mul_res_t;

endpackage

// File: src/fp_decode_stage.sv
module fp_decode_stage
    import fp32_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  fp_word_t  a,
    input  fp_word_t  b,
    output logic      valid,
    output dec_pair_t dec
);

    dec_operand_t a_dec;
    dec_operand_t b_dec;

    // Split one word into class, effective exponent and significand
    function automatic dec_operand_t decode(input fp_word_t w);
        exp_t         e;
        frac_t        f;
        dec_operand_t d;
        e      = w[MAN_BITS +: EXP_BITS];
        f      = w[MAN_BITS-1:0];
        d.sign = w[SGN_BIT];
        if (e == '0) begin
            d.cls = (f == '0) ? FP_ZERO : FP_SUB;
        end else if (e == EXP_MAX) begin
            d.cls = (f == '0) ? FP_INF : FP_NAN;
        end else begin
            d.cls = FP_NORM;
        end
        // Subnormals share the exponent of the smallest normal
        d.exp = (d.cls == FP_SUB) ? exp_t'(1) : e;
        d.sig = {(e != '0), f};                     // Hidden bit clear only for exp 0
        return d;
    endfunction

    always_comb begin
        a_dec = decode(a);
        b_dec = decode(b);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= in_valid;
        end
    end

    // Operand payload, loaded only with a new pair
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec.a <= a_dec;
            dec.b <= b_dec;
        end
    end

endmodule

// File: src/fp_mul_stage.sv
module fp_mul_stage
    import fp32_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      valid_in,
    input  dec_pair_t dec,
    output logic      valid,
    output mul_res_t  res
);

    logic      prod_sign;
    wide_exp_t prov_exp;
    prod_t     prod;

    logic      a_zero;
    logic      b_zero;
    logic      a_inf;
    logic      b_inf;
    logic      res_nan;
    logic      res_inf;
    logic      res_zero;
    fp_word_t  special_word;

    assign prod_sign = dec.a.sign ^ dec.b.sign;

    // Ea + Eb - bias on the wide signed exponent
    assign prov_exp = wide_exp_t'({2'b00, dec.a.exp})
                    + wide_exp_t'({2'b00, dec.b.exp})
                    - wide_exp_t'(FP_BIAS);

    assign prod = dec.a.sig * dec.b.sig;            // 24 x 24 gives 48 bits

    assign a_zero = (dec.a.cls == FP_ZERO);
    assign b_zero = (dec.b.cls == FP_ZERO);
    assign a_inf  = (dec.a.cls == FP_INF);
    assign b_inf  = (dec.b.cls == FP_INF);

    // NaN wins over infinity, infinity over zero
    assign res_nan  = (dec.a.cls == FP_NAN) || (dec.b.cls == FP_NAN)
                   || (a_inf && b_zero) || (b_inf && a_zero);
    assign res_inf  = !res_nan && (a_inf || b_inf);
    assign res_zero = !res_nan && !res_inf && (a_zero || b_zero);

    always_comb begin
        if (res_nan) begin
            special_word = QNAN_WORD;
        end else if (res_inf) begin
            special_word = {prod_sign, exp_t'(EXP_MAX), frac_t'(0)};
        end else if (res_zero) begin
            special_word = {prod_sign, exp_t'(0), frac_t'(0)};
        end else begin
            special_word = '0;                      // Unused on the normal path
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            res.sign       <= prod_sign;
            res.exp        <= prov_exp;
            res.prod       <= prod;
            res.is_special <= res_nan || res_inf || res_zero;
            res.special    <= special_word;
        end
    end

endmodule

// File: src/fp_normalizer.sv
module fp_normalizer
    import fp32_pkg::*;
(
    input  prod_t     prod,
    input  wide_exp_t exp_in,
    output prod_t     norm,
    output wide_exp_t exp_out
);

    // Binary point sits between bits 46 and 45 of the product
    localparam int TOP_BIT = 2 * MAN_BITS;          // Position of the leading one after norm

    logic [5:0] lead_zeros;
    logic       carry_bit;

    assign carry_bit = prod[TOP_BIT+1];             // Product in [2, 4)

    // Priority encoder over bits 46 down to 0
    // Higher set bits overwrite lower ones as the loop climbs
    always_comb begin
        lead_zeros = '0;
        for (int i = 0; i <= TOP_BIT; i++) begin
            if (prod[i]) begin
                lead_zeros = 6'(TOP_BIT - i);
            end
        end
    end

    // Operands reaching here are nonzero, so a leading one always exists
    always_comb begin
        if (carry_bit) begin
            norm    = (prod >> 1) | prod_t'(prod[0]);   // Dropped bit stays in the sticky range
            exp_out = exp_in + wide_exp_t'(1);
        end else begin
            norm    = prod << lead_zeros;           // Subnormal inputs need the left shift
            exp_out = exp_in - wide_exp_t'({4'b0000, lead_zeros});
        end
    end

endmodule

// File: src/fp_round_stage.sv
module fp_round_stage
    import fp32_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     valid_in,
    input  mul_res_t res,
    output logic     out_valid,
    output fp_word_t result
);

    prod_t                norm_prod;
    wide_exp_t            norm_exp;

    frac_t                frac_raw;
    logic                 guard_bit;
    logic                 round_bit;
    logic                 sticky_bit;
    logic                 round_up;
    logic [MAN_BITS:0]    frac_sum;                 // Extra bit catches the carry
    wide_exp_t            final_exp;
    fp_word_t             word_next;

    fp_normalizer u_norm (
        .prod    (res.prod),
        .exp_in  (res.exp),
        .norm    (norm_prod),
        .exp_out (norm_exp)
    );

    // Fraction bits 45..23, guard 22, round 21, sticky 20..0
    assign frac_raw   = norm_prod[2*MAN_BITS-1 -: MAN_BITS];
    assign guard_bit  = norm_prod[MAN_BITS-1];
    assign round_bit  = norm_prod[MAN_BITS-2];
    assign sticky_bit = |norm_prod[MAN_BITS-3:0];

    // Nearest even, a tie only rounds up from an odd fraction
    assign round_up = guard_bit && (round_bit || sticky_bit || frac_raw[0]);
    assign frac_sum = {1'b0, frac_raw} + (MAN_BITS+1)'(round_up);

    assign final_exp = norm_exp + wide_exp_t'({9'd0, frac_sum[MAN_BITS]});

    always_comb begin
        if (res.is_special) begin
            word_next = res.special;
        end else if (final_exp >= EXP_MAX) begin
            word_next = {res.sign, exp_t'(EXP_MAX), frac_t'(0)};  // Overflow to infinity
        end else if (final_exp <= 0) begin
            word_next = {res.sign, exp_t'(0), frac_t'(0)};        // Flush to signed zero
        end else begin
            // Carry out leaves the fraction all zero, so no reshift is needed
            word_next = {res.sign, exp_t'(final_exp), frac_sum[MAN_BITS-1:0]};
        end
    end

    // Result is held between pulses and cleared by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= valid_in;
            if (valid_in) begin
                result <= word_next;
            end
        end
    end

endmodule

// File: verif/fp32_mul_chk.sv
module fp32_mul_chk
    import fp32_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     in_valid,
    input logic     out_valid,
    input fp_word_t result
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned n_fail = 0;                        // Failed assertions so far

    // Three register stages between in_valid and out_valid
    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 3))
        else begin
            $error("out_valid does not follow in_valid by three cycles");
            n_fail++;
        end

    // The output register only loads together with a pulse
    result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> $stable(result))
        else begin
            $error("result changed while out_valid was low");
            n_fail++;
        end

    // Every NaN leaving the pipeline is the canonical one
    nan_canonical: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && result[MAN_BITS +: EXP_BITS] == EXP_MAX
            && result[MAN_BITS-1:0] != '0) |-> result == QNAN_WORD)
        else begin
            $error("non-canonical NaN on result: %08h", result);
            n_fail++;
        end

endmodule

bind fp32_mul fp32_mul_chk fp32_mul_chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result)
);

// File: verif/fp32_mul_tb.sv
module fp32_mul_tb
    import fp32_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF     = 50;
    localparam int CLK_PERIOD   = 2 * CLK_HALF;
    localparam int DRIVE_DLY    = 10;               // Input skew after the rising edge
    localparam int RESET_CYCLES = 8;
    localparam int RAND_SEED    = 33;
    localparam int DIRECTED_OPS = 40;               // Upper bound over the directed tests
    localparam int STREAM_OPS   = 200;
    localparam int MAX_GAP      = 2;
    localparam int N_TESTS      = 6;
    localparam int DRAIN_CYCLES = 20;               // Per-test wait for the pipeline to empty
    localparam int TOTAL_OPS    = DIRECTED_OPS + STREAM_OPS;
    // Every op may carry its worst gap, every test its drain, plus slack
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_OPS * (MAX_GAP + 1)
                                   + N_TESTS * DRAIN_CYCLES + 50;

    typedef struct packed {
        fp_word_t a;
        fp_word_t b;
        fp_word_t expected;
    } txn_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    fp_word_t a;
    fp_word_t b;
    logic     out_valid;
    fp_word_t result;

    txn_t        exp_q[$];                          // Expected results in issue order
    int          n_issued = 0;

    fp32_mul fp32_mul_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .a         (a),
        .b         (b),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .result    (result)
    );

    always #(CLK_HALF) clk = ~clk;

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %08h expected %08h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    function automatic fp_class_e classify(input fp_word_t w);
        if (w[30:23] == 8'h00) begin
            return (w[22:0] == '0) ? FP_ZERO : FP_SUB;
        end else if (w[30:23] == 8'hFF) begin
            return (w[22:0] == '0) ? FP_INF : FP_NAN;
        end
        return FP_NORM;
    endfunction

    // Magnitude of a finite word as an exact double
    function automatic real magnitude(input fp_word_t w);
        real         two_m149;
        logic [63:0] bits;
        two_m149 = $bitstoreal({1'b0, 11'd874, 52'd0});     // 2^-149, subnormal LSB
        if (w[30:23] == 8'h00) begin
            return $itor(w[22:0]) * two_m149;
        end
        bits = {1'b0, 11'(int'(w[30:23]) - 127 + 1023), w[22:0], 29'd0};
        return $bitstoreal(bits);
    endfunction

    function automatic fp_word_t model_mul(input fp_word_t x, input fp_word_t y);
        logic        sign;
        fp_class_e   cx;
        fp_class_e   cy;
        logic [63:0] pbits;
        logic [23:0] frac_sum;
        int          e;
        sign = x[31] ^ y[31];
        cx   = classify(x);
        cy   = classify(y);
        if (cx == FP_NAN || cy == FP_NAN || (cx == FP_INF && cy == FP_ZERO)
                || (cy == FP_INF && cx == FP_ZERO)) begin
            return QNAN_WORD;
        end
        if (cx == FP_INF || cy == FP_INF) begin
            return {sign, 8'hFF, 23'd0};
        end
        if (cx == FP_ZERO || cy == FP_ZERO) begin
            return {sign, 31'd0};
        end
        pbits    = $realtobits(magnitude(x) * magnitude(y));  // 48-bit product fits exactly
        e        = int'(pbits[62:52]) - 1023 + FP_BIAS;
        frac_sum = {1'b0, pbits[51:29]};
        // Guard is bit 28, sticky covers the rest, ties go to the even fraction
        if (pbits[28] && ((|pbits[27:0]) || pbits[29])) begin
            frac_sum = frac_sum + 24'd1;
        end
        if (frac_sum[23]) begin
            e = e + 1;                              // Fraction wrapped to zero
        end
        if (e >= EXP_MAX) begin
            return {sign, 8'hFF, 23'd0};
        end else if (e <= 0) begin
            return {sign, 31'd0};                   // Flush below the smallest normal
        end
        return {sign, 8'(e), frac_sum[22:0]};
    endfunction

    task automatic issue(input fp_word_t x, input fp_word_t y);
        txn_t t;
        @(posedge clk);
        #(DRIVE_DLY);
        a          = x;
        b          = y;
        in_valid   = 1'b1;
        t.a        = x;
        t.b        = y;
        t.expected = model_mul(x, y);
        exp_q.push_back(t);
        n_issued++;
    endtask

    // Hand-derived value keeps the model honest
    task automatic issue_expect(input fp_word_t x, input fp_word_t y, input fp_word_t want);
        check_value(model_mul(x, y), want, $sformatf("model for a=%08h b=%08h", x, y));
        issue(x, y);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #(DRIVE_DLY);
        in_valid = 1'b0;
    endtask

    task automatic wait_results(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
    endtask

    function automatic fp_word_t random_operand();
        fp_word_t w;
        w = $urandom;
        case ($urandom_range(0, 7))
            0:       w[30:23] = 8'h00;              // Zero or subnormal
            1:       w[30:23] = 8'hFF;              // Infinity or NaN
            7:       w = w;                         // Fully random word
            default: w[30:23] = 8'($urandom_range(64, 190));
        endcase
        return w;
    endfunction

    // Outputs settle at the rising edge, so sample on the falling one
    always @(negedge clk) begin
        txn_t t;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("Output pulse at %0t with no operation outstanding", $time);
                stop_with_failure();
            end else begin
                t = exp_q.pop_front();
                check_value(result, t.expected,
                            $sformatf("result for a=%08h b=%08h", t.a, t.b));
            end
        end
    end

    // Any failed assertion in the bound checker ends the run
    initial begin
        wait (fp32_mul_i.fp32_mul_chk_i.n_fail != 0);
        $display("An assertion in the bound checker failed at %0t", $time);
        stop_with_failure();
    end

    task automatic idle_after_reset();
        @(negedge clk);
        check_value(out_valid, 0, "out_valid after reset");
        check_value(result, 0, "result after reset");
        repeat (10) begin
            idle_cycle();
            @(negedge clk);
            check_value(out_valid, 0, "out_valid while idle");
        end
    endtask

    task automatic exact_products();
        issue_expect(32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000);  // 1.5 x 2.0
        issue_expect(32'hC040_0000, 32'h3F00_0000, 32'hBFC0_0000);  // -3.0 x 0.5
        issue_expect(32'h3F80_0000, 32'h1234_5678, 32'h1234_5678);  // 1.0 x x
        issue_expect(32'hBF80_0000, 32'h4049_0FDB, 32'hC049_0FDB);
        issue_expect(32'hC000_0000, 32'hC080_0000, 32'h4100_0000);  // -2 x -4
        idle_cycle();
        wait_results(DRAIN_CYCLES);
    endtask

    task automatic special_cases();
        issue_expect(32'h7FC0_0000, 32'h3F80_0000, QNAN_WORD);
        issue_expect(32'h7F80_0001, 32'h0000_0000, QNAN_WORD);      // Signaling NaN x zero
        issue_expect(32'hFFC0_0001, 32'h7F80_0000, QNAN_WORD);
        issue_expect(32'h7F80_0000, 32'h8000_0000, QNAN_WORD);      // Inf x -0
        issue_expect(32'h0000_0000, 32'hFF80_0000, QNAN_WORD);
        issue_expect(32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000);
        issue_expect(32'hFF80_0000, 32'h0000_0001, 32'hFF80_0000);  // Subnormal is nonzero
        issue_expect(32'h7F80_0000, 32'h7F80_0000, 32'h7F80_0000);
        issue_expect(32'h0000_0000, 32'h4040_0000, 32'h0000_0000);
        issue_expect(32'h0000_0000, 32'hC040_0000, 32'h8000_0000);
        idle_cycle();
        wait_results(DRAIN_CYCLES);
    endtask

    task automatic rounding_cases();
        issue_expect(32'h3F80_0800, 32'h3F80_0800, 32'h3F80_1000);  // Tie, already even
        issue_expect(32'h3FC0_0000, 32'h3F80_0001, 32'h3FC0_0002);  // Tie, odd rounds up
        issue_expect(32'h3F80_0801, 32'h3F80_0800, 32'h3F80_1002);  // Just above half
        issue_expect(32'h3FD5_5555, 32'h3FFF_FFFD, 32'h4055_5553);  // Only bit 0 is sticky
        issue_expect(32'h3F80_0001, 32'h3FFF_FFFE, 32'h4000_0000);  // Carry bumps exponent
        issue_expect(32'h7F00_0001, 32'h3FFF_FFFE, 32'h7F80_0000);  // Carry into overflow
        idle_cycle();
        wait_results(DRAIN_CYCLES);
    endtask

    task automatic range_limits();
        issue_expect(32'h7F00_0000, 32'h7F00_0000, 32'h7F80_0000);
        issue_expect(32'h7F00_0000, 32'hFF00_0000, 32'hFF80_0000);
        issue_expect(32'h0080_0000, 32'h0080_0000, 32'h0000_0000);
        issue_expect(32'h8080_0000, 32'h0080_0000, 32'h8000_0000);
        issue_expect(32'h1F80_0000, 32'h2000_0000, 32'h0000_0000);  // 2^-127 flushes
        issue_expect(32'h0000_0001, 32'h7F00_0000, 32'h3480_0000);  // 2^-149 x 2^127
        issue_expect(32'h0040_0000, 32'h4000_0000, 32'h0080_0000);
        issue_expect(32'h0000_0003, 32'h4B00_0000, 32'h0140_0000);
        issue_expect(32'h0000_0005, 32'h0000_0007, 32'h0000_0000);
        idle_cycle();
        wait_results(DRAIN_CYCLES);
    endtask

    task automatic random_stream();
        int gap;
        for (int i = 0; i < STREAM_OPS / 2; i++) begin
            issue(random_operand(), random_operand());
        end
        for (int i = 0; i < STREAM_OPS / 2; i++) begin
            issue(random_operand(), random_operand());
            gap = $urandom_range(0, MAX_GAP);
            repeat (gap) idle_cycle();
        end
        idle_cycle();
        wait_results(DRAIN_CYCLES);
    endtask

    task automatic finish_run();
        wait_results(DRAIN_CYCLES);
        if (exp_q.size() != 0) begin
            $display("Run ended with %0d of %0d results never delivered",
                     exp_q.size(), n_issued);
            stop_with_failure();
        end else begin
            $display("all tests passed");
            $finish;
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        stop_with_failure();
    end

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        void'($urandom(RAND_SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        $display("Running reset test");
        idle_after_reset();
        $display("Running exact products");
        exact_products();
        $display("Running special cases");
        special_cases();
        $display("Running rounding");
        rounding_cases();
        $display("Running range and subnormal inputs");
        range_limits();
        $display("Running streaming");
        random_stream();
        finish_run();
    end

endmodule
